//--- sources.f
+incdir+.
rv_isa_pkg.sv
core_io_pkg.sv
instr_decoder.sv
exec_unit.sv
writeback_regfile.sv
csr_field.sv
mini_core_top.sv
mini_core_checker.sv
tb_mini_core.sv

//--- Makefile
# Verilator build and run of the mini core testbench
VERILATOR ?= verilator
TOP       ?= tb_mini_core
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST)) core_defines.svh
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) 2>&1 | tee $(LOG)
	@grep -qx 'STATUS: PASS' $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb_mini_core.sv
// mini core testbench driving LCG stimulus and checking traces against a reference model
`default_nettype none

`include "core_defines.svh"

module tb_mini_core;
  timeunit 1ns;
  timeprecision 1ps;

  logic                clk;
  logic                rst_n;
  logic [`XLEN-1:0]    instr;
  logic                instr_valid;
  core_io_pkg::btn_t   btn;
  core_io_pkg::led_t   led;
  core_io_pkg::trace_t trace;

  // reference model state
  logic [31:0]         model_regs [`REG_COUNT];
  core_io_pkg::led_t   model_led;
  core_io_pkg::btn_t   model_btn;
  core_io_pkg::trace_t exp_q [$];
  int unsigned         exp_cyc_q [$];
  core_io_pkg::led_t   led_exp_q [$];
  int unsigned         led_due_q [$];

  logic [31:0] lcg_state = 32'd71292;
  int unsigned cycle = 0;
  int unsigned value_errs = 0;
  int unsigned other_errs = 0;
  int unsigned checked = 0;

  mini_core_top u_dut (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .instr_i       (instr),
    .instr_valid_i (instr_valid),
    .btn_i         (btn),
    .led_o         (led),
    .trace_o       (trace)
  );

  bind mini_core_top mini_core_checker u_checker (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .instr_valid_i (instr_valid_i),
    .trace_i       (trace_o)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // upper bits only, the low ones have short periods
  function automatic logic [31:0] pick_below(input logic [31:0] n);
    return (lcg_next() >> 16) % n;
  endfunction

  // mostly a few low registers so results get reused
  function automatic logic [4:0] reg_pick();
    if (pick_below(4) == 0) begin
      return 5'(pick_below(32));
    end
    return 5'(pick_below(8));
  endfunction

  // RV32I meaning of funct3, alt picks sub or sra
  function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
    logic [31:0] r;
    case (f3)
      3'd0: r = alt ? a - b : a + b;
      3'd1: r = a << b[4:0];
      3'd2: r = {31'd0, (a[31] != b[31]) ? a[31] : (a < b)};
      3'd3: r = {31'd0, a < b};
      3'd4: r = a ^ b;
      3'd5: begin
        r = a >> b[4:0];
        // fill vacated bits with the sign
        if (alt && a[31]) begin
          r = r | ~(32'hFFFF_FFFF >> b[4:0]);
        end
      end
      3'd6: r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    checked++;
    if (got !== exp) begin
      value_errs++;
      $display("ERR %0d ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // drive one instruction for a cycle and record what must retire
  task automatic issue_instr(input logic [31:0] word, input logic ill, input logic [4:0] rd,
                             input logic [31:0] data);
    core_io_pkg::trace_t e;
    e         = '0;
    e.valid   = 1'b1;
    e.illegal = ill;
    e.rd      = ill ? 5'd0 : rd;
    e.data    = ill ? 32'd0 : data;
    if (!ill && rd != 5'd0) begin
      model_regs[rd] = data;
    end
    exp_q.push_back(e);
    exp_cyc_q.push_back(cycle + 3);
    instr       = word;
    instr_valid = 1'b1;
    @(negedge clk);
    instr_valid = 1'b0;
  endtask

  task automatic issue_random();
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic        alt;
    logic [11:0] imm;
    logic [31:0] a;
    logic [31:0] rnd;
    logic [31:0] old;
    int unsigned kind;
    kind = pick_below(16);
    rd   = reg_pick();
    rs1  = reg_pick();
    rs2  = reg_pick();
    f3   = 3'(pick_below(8));
    alt  = (pick_below(2) != 0);
    rnd  = lcg_next();
    a    = model_regs[rs1];
    case (kind)
      5, 6, 7, 8: begin
        imm = rnd[11:0];
        if (f3 == 3'd1) begin
          imm = {7'd0, rnd[4:0]};
        end else if (f3 == 3'd5) begin
          imm = {1'b0, alt, 5'd0, rnd[4:0]};
        end
        issue_instr({imm, rs1, f3, rd, 7'b0010011}, 1'b0, rd,
                    alu_model(f3, f3 == 3'd5 && alt, a, {{20{imm[11]}}, imm}));
      end
      9, 10: issue_instr({rnd[31:12], rd, 7'b0110111}, 1'b0, rd, {rnd[31:12], 12'd0});
      11, 12: begin
        old = 32'(model_led);
        // csrrs when alt, csrrw otherwise
        if (alt) begin
          model_led = model_led | a[`LED_WIDTH-1:0];
        end else begin
          model_led = a[`LED_WIDTH-1:0];
        end
        led_due_q.push_back(cycle + 2);
        led_exp_q.push_back(model_led);
        issue_instr({`CSR_LED_ADDR, rs1, alt ? 3'b010 : 3'b001, rd, 7'b1110011}, 1'b0, rd, old);
      end
      13: issue_instr({`CSR_BTN_ADDR, 5'd0, 3'b010, rd, 7'b1110011}, 1'b0, rd,
                      32'(model_btn));
      14: begin
        // load opcode is unknown to the core
        issue_instr({rnd[31:7], 7'b0000011}, 1'b1, 5'd0, 32'd0);
        issue_instr({12'd0, rnd[11:7], 3'b000, rd, 7'b0010011}, 1'b0, rd,
                    model_regs[rnd[11:7]]);
      end
      default: begin
        if (f3 != 3'd0 && f3 != 3'd5) begin
          alt = 1'b0;
        end
        issue_instr({1'b0, alt, 5'd0, rs2, rs1, f3, rd, 7'b0110011}, 1'b0, rd,
                    alu_model(f3, alt, a, model_regs[rs2]));
      end
    endcase
  endtask

  // wait until every issued instruction has retired
  task automatic wait_retired();
    int unsigned n;
    n = 0;
    while (exp_q.size() != 0 && n < 20) begin
      @(negedge clk);
      n++;
    end
    if (exp_q.size() != 0) begin
      other_errs++;
      $display("timeout: %0d instructions never retired", exp_q.size());
      exp_q.delete();
      exp_cyc_q.delete();
    end
    check_value("led_o when idle", 32'(led), 32'(model_led));
  endtask

  // buttons only move while the pipeline is idle
  task automatic change_buttons();
    repeat (4) @(negedge clk);
    btn = core_io_pkg::btn_t'(pick_below(16));
    repeat (4) @(negedge clk);
    model_btn = btn;
  endtask

  always @(negedge clk) begin
    core_io_pkg::trace_t e;
    core_io_pkg::led_t   le;
    int unsigned         due;
    if (led_due_q.size() != 0 && led_due_q[0] == cycle) begin
      due = led_due_q.pop_front();
      le  = led_exp_q.pop_front();
      check_value("led_o after csr write", 32'(led), 32'(le));
    end
    if (rst_n && trace.valid === 1'b1) begin
      if (exp_q.size() == 0) begin
        other_errs++;
        $display("unexpected trace entry at %0d ns with nothing outstanding", $time);
      end else begin
        e   = exp_q.pop_front();
        due = exp_cyc_q.pop_front();
        check_value("trace cycle", cycle, due);
        check_value("trace illegal", 32'(trace.illegal), 32'(e.illegal));
        check_value("trace rd", 32'(trace.rd), 32'(e.rd));
        check_value("trace data", trace.data, e.data);
      end
    end
  end

  initial begin
    int unsigned fails;
    clk         = 1'b0;
    rst_n       = 1'b0;
    instr       = '0;
    instr_valid = 1'b0;
    btn         = '0;
    model_led   = '0;
    model_btn   = '0;
    for (int i = 0; i < `REG_COUNT; i++) begin
      model_regs[i] = '0;
    end
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    // back to back, both forwarding paths get exercised
    repeat (200) issue_random();
    wait_retired();
    change_buttons();
    for (int round = 0; round < 4; round++) begin
      for (int k = 0; k < 100; k++) begin
        issue_random();
        if (pick_below(4) == 0) begin
          repeat (1 + pick_below(3)) @(negedge clk);
        end
      end
      wait_retired();
      change_buttons();
    end
    wait_retired();
    fails = u_dut.u_checker.fail_cnt;
    $display("checks %0d, value errors %0d, other errors %0d, assertion failures %0d",
             checked, value_errs, other_errs, fails);
    if (value_errs == 0 && other_errs == 0 && fails == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- mini_core_checker.sv
// mini core assertion checker on reset, trace latency and illegal retire entries
`default_nettype none

module mini_core_checker (
  input logic                clk_i,
  input logic                rst_n_i,
  input logic                instr_valid_i,
  input core_io_pkg::trace_t trace_i
);
  timeunit 1ns;
  timeprecision 1ps;

  int unsigned fail_cnt = 0;

  // a reset edge clears the trace register
  a_reset_quiet: assert property (@(posedge clk_i) !rst_n_i |=> !trace_i.valid)
    else begin
      fail_cnt++;
      $error("trace valid high right after a reset edge");
    end

  // pipeline refills for three edges after reset
  a_refill_quiet: assert property (@(posedge clk_i)
    $rose(rst_n_i) |-> !trace_i.valid ##1 !trace_i.valid ##1 !trace_i.valid)
    else begin
      fail_cnt++;
      $error("trace valid high within three cycles of reset release");
    end

  // fixed latency of three edges, bubbles included
  a_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    trace_i.valid == $past(instr_valid_i, 3))
    else begin
      fail_cnt++;
      $error("trace valid does not follow the instruction strobe by three edges");
    end

  a_illegal_rd: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    trace_i.valid && trace_i.illegal |-> trace_i.rd == '0)
    else begin
      fail_cnt++;
      $error("illegal trace entry carries a destination register");
    end

endmodule

`default_nettype wire

//--- mini_core_top.sv
// top level of the three stage core slice with LED and button CSRs
`default_nettype none

`include "core_defines.svh"

module mini_core_top (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic [`XLEN-1:0]    instr_i,
  input  logic                instr_valid_i,
  input  core_io_pkg::btn_t   btn_i,
  output core_io_pkg::led_t   led_o,
  output core_io_pkg::trace_t trace_o
);

  rv_isa_pkg::decoded_t     dec;
  rv_isa_pkg::exec_result_t res;
  rv_isa_pkg::reg_idx_t     rs1_idx;
  rv_isa_pkg::reg_idx_t     rs2_idx;
  logic [`XLEN-1:0]         rs1_data;
  logic [`XLEN-1:0]         rs2_data;
  logic                     csr_wr;
  logic [`XLEN-1:0]         csr_wdata;
  core_io_pkg::led_t        led_val;
  core_io_pkg::btn_t        btn_val;

  instr_decoder u_decoder (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .instr_i       (instr_i),
    .instr_valid_i (instr_valid_i),
    .dec_o         (dec)
  );

  exec_unit u_exec (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .dec_i       (dec),
    .rs1_data_i  (rs1_data),
    .rs2_data_i  (rs2_data),
    .led_val_i   (led_val),
    .btn_val_i   (btn_val),
    .rs1_idx_o   (rs1_idx),
    .rs2_idx_o   (rs2_idx),
    .csr_wr_o    (csr_wr),
    .csr_wdata_o (csr_wdata),
    .res_o       (res)
  );

  writeback_regfile u_wb (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .res_i      (res),
    .rs1_idx_i  (rs1_idx),
    .rs2_idx_i  (rs2_idx),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .trace_o    (trace_o)
  );

  // LED register, written by csrrw/csrrs
  csr_field #(
    .payload_t (core_io_pkg::led_t),
    .WRITABLE  (1'b1)
  ) u_led_csr (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .wr_i    (csr_wr),
    .wdata_i (csr_wdata),
    .ext_i   (core_io_pkg::led_t'('0)),
    .val_o   (led_val)
  );

  // buttons are read only
  csr_field #(
    .payload_t (core_io_pkg::btn_t),
    .WRITABLE  (1'b0)
  ) u_btn_csr (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .wr_i    (1'b0),
    .wdata_i (csr_wdata),
    .ext_i   (btn_i),
    .val_o   (btn_val)
  );

  assign led_o = led_val;

endmodule

`default_nettype wire

//--- csr_field.sv
// single CSR, either CPU-writable or a synchronized read-only input
`default_nettype none

`include "core_defines.svh"

module csr_field #(
  parameter type payload_t = logic [3:0],
  parameter bit  WRITABLE  = 1'b1
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             wr_i,
  input  logic [`XLEN-1:0] wdata_i,
  input  payload_t         ext_i,
  output payload_t         val_o
);

  payload_t val_q;

  if (WRITABLE) begin : g_rw
    // takes the low bits of the write data
    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        val_q <= '0;
      end else if (wr_i) begin
        val_q <= payload_t'(wdata_i[$bits(payload_t)-1:0]);
      end
    end
  end else begin : g_ro
    payload_t sync_q;

    // two flop synchronizer on the external level
    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        sync_q <= '0;
        val_q  <= '0;
      end else begin
        sync_q <= ext_i;
        val_q  <= sync_q;
      end
    end
  end

  assign val_o = val_q;

endmodule

`default_nettype wire

//--- writeback_regfile.sv
// result stage, register file with write bypass and the retire trace register
`default_nettype none

`include "core_defines.svh"

module writeback_regfile (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  rv_isa_pkg::exec_result_t res_i,
  input  rv_isa_pkg::reg_idx_t     rs1_idx_i,
  input  rv_isa_pkg::reg_idx_t     rs2_idx_i,
  output logic [`XLEN-1:0]         rs1_data_o,
  output logic [`XLEN-1:0]         rs2_data_o,
  output core_io_pkg::trace_t      trace_o
);

  // x0 has no storage
  logic [`XLEN-1:0]     regs [1:`REG_COUNT-1];
  logic                 wr_en;
  rv_isa_pkg::reg_idx_t rd_idx  [2];
  logic [`XLEN-1:0]     rd_data [2];
  core_io_pkg::trace_t  trace_d;
  core_io_pkg::trace_t  trace_q;

  assign wr_en = res_i.valid && res_i.wb_en && res_i.rd != '0;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 1; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[res_i.rd] <= res_i.data;
    end
  end

  assign rd_idx[0] = rs1_idx_i;
  assign rd_idx[1] = rs2_idx_i;

  // read ports see the value written at the coming edge
  for (genvar p = 0; p < 2; p++) begin : g_read
    always_comb begin
      if (rd_idx[p] == '0) begin
        rd_data[p] = '0;
      end else if (wr_en && res_i.rd == rd_idx[p]) begin
        rd_data[p] = res_i.data;
      end else begin
        rd_data[p] = regs[rd_idx[p]];
      end
    end
  end

  assign rs1_data_o = rd_data[0];
  assign rs2_data_o = rd_data[1];

  always_comb begin
    trace_d = '0;
    if (res_i.valid) begin
      trace_d.valid   = 1'b1;
      trace_d.illegal = res_i.illegal;
      // illegal entries carry no destination
      trace_d.rd      = res_i.illegal ? '0 : res_i.rd;
      trace_d.data    = res_i.illegal ? '0 : res_i.data;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      trace_q <= '0;
    end else begin
      trace_q <= trace_d;
    end
  end

  assign trace_o = trace_q;

endmodule

`default_nettype wire

//--- exec_unit.sv
// execute stage with operand forwarding, ALU and CSR access, result registered
`default_nettype none

`include "core_defines.svh"

module exec_unit (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  rv_isa_pkg::decoded_t     dec_i,
  input  logic [`XLEN-1:0]         rs1_data_i,
  input  logic [`XLEN-1:0]         rs2_data_i,
  input  core_io_pkg::led_t        led_val_i,
  input  core_io_pkg::btn_t        btn_val_i,
  output rv_isa_pkg::reg_idx_t     rs1_idx_o,
  output rv_isa_pkg::reg_idx_t     rs2_idx_o,
  output logic                     csr_wr_o,
  output logic [`XLEN-1:0]         csr_wdata_o,
  output rv_isa_pkg::exec_result_t res_o
);

  rv_isa_pkg::exec_result_t res_d;
  rv_isa_pkg::exec_result_t res_q;

  logic             fwd_rs1;
  logic             fwd_rs2;
  logic [`XLEN-1:0] op_a;
  logic [`XLEN-1:0] rs2_val;
  logic [`XLEN-1:0] op_b;
  logic [`XLEN-1:0] alu_res;
  logic [`XLEN-1:0] csr_old;
  logic             csr_en;

  assign rs1_idx_o = dec_i.rs1;
  assign rs2_idx_o = dec_i.rs2;

  // result one ahead still sits in the execute register
  // x0 is never forwarded
  assign fwd_rs1 = res_q.valid && res_q.wb_en && res_q.rd == dec_i.rs1 && dec_i.rs1 != '0;
  assign fwd_rs2 = res_q.valid && res_q.wb_en && res_q.rd == dec_i.rs2 && dec_i.rs2 != '0;

  assign op_a    = fwd_rs1 ? res_q.data : rs1_data_i;
  assign rs2_val = fwd_rs2 ? res_q.data : rs2_data_i;
  assign op_b    = dec_i.use_imm ? dec_i.imm : rs2_val;

  always_comb begin
    case (dec_i.alu_op)
      rv_isa_pkg::ALU_ADD:  alu_res = op_a + op_b;
      rv_isa_pkg::ALU_SUB:  alu_res = op_a - op_b;
      rv_isa_pkg::ALU_SLL:  alu_res = op_a << op_b[4:0];
      rv_isa_pkg::ALU_SLT:  alu_res = `XLEN'($signed(op_a) < $signed(op_b));
      rv_isa_pkg::ALU_SLTU: alu_res = `XLEN'(op_a < op_b);
      rv_isa_pkg::ALU_XOR:  alu_res = op_a ^ op_b;
      rv_isa_pkg::ALU_SRL:  alu_res = op_a >> op_b[4:0];
      rv_isa_pkg::ALU_SRA:  alu_res = $unsigned($signed(op_a) >>> op_b[4:0]);
      rv_isa_pkg::ALU_OR:   alu_res = op_a | op_b;
      default:              alu_res = op_a & op_b;
    endcase
  end

  // old CSR value, zero-extended, unknown addresses read 0
  always_comb begin
    case (dec_i.csr_addr)
      `CSR_LED_ADDR: csr_old = `XLEN'(led_val_i);
      `CSR_BTN_ADDR: csr_old = `XLEN'(btn_val_i);
      default:       csr_old = '0;
    endcase
  end

  assign csr_en      = dec_i.valid && !dec_i.illegal && dec_i.csr_op != rv_isa_pkg::CSR_NONE;
  assign csr_wdata_o = (dec_i.csr_op == rv_isa_pkg::CSR_SET) ? (csr_old | op_a) : op_a;

  // csrrs with rs1 = x0 is a pure read
  assign csr_wr_o = csr_en && dec_i.csr_addr == `CSR_LED_ADDR &&
                    (dec_i.csr_op == rv_isa_pkg::CSR_WRITE || dec_i.rs1 != '0);

  always_comb begin
    res_d         = '0;
    res_d.valid   = dec_i.valid;
    res_d.rd      = dec_i.rd;
    res_d.wb_en   = dec_i.valid && dec_i.wb_en && !dec_i.illegal;
    res_d.illegal = dec_i.valid && dec_i.illegal;
    res_d.data    = csr_en ? csr_old : alu_res;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      res_q <= '0;
    end else begin
      res_q <= res_d;
    end
  end

  assign res_o = res_q;

endmodule

`default_nettype wire

//--- instr_decoder.sv
// decode stage, turns an instruction word into a registered control struct
`default_nettype none

`include "core_defines.svh"

module instr_decoder (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic [`XLEN-1:0]     instr_i,
  input  logic                 instr_valid_i,
  output rv_isa_pkg::decoded_t dec_o
);

  rv_isa_pkg::decoded_t dec_d;
  rv_isa_pkg::decoded_t dec_q;

  logic [2:0] funct3;
  logic [6:0] funct7;

  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  // funct3 plus the alternate bit (instr[30]) to ALU function
  function automatic rv_isa_pkg::alu_op_e alu_map(logic [2:0] f3, logic alt);
    rv_isa_pkg::alu_op_e op;
    case (rv_isa_pkg::funct3_e'(f3))
      rv_isa_pkg::F3_ADD_SUB: op = alt ? rv_isa_pkg::ALU_SUB : rv_isa_pkg::ALU_ADD;
      rv_isa_pkg::F3_SLL:     op = rv_isa_pkg::ALU_SLL;
      rv_isa_pkg::F3_SLT:     op = rv_isa_pkg::ALU_SLT;
      rv_isa_pkg::F3_SLTU:    op = rv_isa_pkg::ALU_SLTU;
      rv_isa_pkg::F3_XOR:     op = rv_isa_pkg::ALU_XOR;
      rv_isa_pkg::F3_SRL_SRA: op = alt ? rv_isa_pkg::ALU_SRA : rv_isa_pkg::ALU_SRL;
      rv_isa_pkg::F3_OR:      op = rv_isa_pkg::ALU_OR;
      default:                op = rv_isa_pkg::ALU_AND;
    endcase
    return op;
  endfunction

  always_comb begin
    dec_d          = '0;
    dec_d.valid    = instr_valid_i;
    dec_d.rs1      = instr_i[19:15];
    dec_d.rs2      = instr_i[24:20];
    dec_d.rd       = instr_i[11:7];
    dec_d.csr_addr = instr_i[31:20];
    dec_d.wb_en    = 1'b1;
    case (rv_isa_pkg::opcode_e'(instr_i[6:0]))
      rv_isa_pkg::OPC_OP: begin
        dec_d.alu_op = alu_map(funct3, funct7[5]);
        // only sub and sra take the alternate encoding
        if (funct7 == 7'b0100000) begin
          dec_d.illegal = !(funct3 == 3'b000 || funct3 == 3'b101);
        end else begin
          dec_d.illegal = (funct7 != 7'b0000000);
        end
      end
      rv_isa_pkg::OPC_OP_IMM: begin
        dec_d.use_imm = 1'b1;
        dec_d.imm     = {{(`XLEN-12){instr_i[31]}}, instr_i[31:20]};
        // addi has no subtract form, srai is the only alternate
        dec_d.alu_op  = alu_map(funct3, funct7[5] && funct3 == 3'b101);
        if (funct3 == 3'b001) begin
          dec_d.illegal = (funct7 != 7'b0000000);
        end else if (funct3 == 3'b101) begin
          dec_d.illegal = !(funct7 == 7'b0000000 || funct7 == 7'b0100000);
        end
      end
      rv_isa_pkg::OPC_LUI: begin
        // x0 + upper immediate
        dec_d.use_imm = 1'b1;
        dec_d.imm     = {instr_i[31:12], 12'b0};
        dec_d.rs1     = '0;
        dec_d.alu_op  = rv_isa_pkg::ALU_ADD;
      end
      rv_isa_pkg::OPC_SYSTEM: begin
        if (funct3 == rv_isa_pkg::F3_CSRRW) begin
          dec_d.csr_op = rv_isa_pkg::CSR_WRITE;
        end else if (funct3 == rv_isa_pkg::F3_CSRRS) begin
          dec_d.csr_op = rv_isa_pkg::CSR_SET;
        end else begin
          dec_d.illegal = 1'b1;
        end
      end
      default: dec_d.illegal = 1'b1;
    endcase
    if (dec_d.illegal) begin
      dec_d.wb_en  = 1'b0;
      dec_d.csr_op = rv_isa_pkg::CSR_NONE;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      dec_q <= '0;
    end else begin
      dec_q <= dec_d;
    end
  end

  assign dec_o = dec_q;

endmodule

`default_nettype wire

//--- core_io_pkg.sv
// board I/O types and the retire trace record of the core
`default_nettype none

`include "core_defines.svh"

package core_io_pkg;

  typedef logic [`LED_WIDTH-1:0] led_t;
  typedef logic [`BTN_WIDTH-1:0] btn_t;

  // one entry per retired instruction
  typedef struct packed {
    logic                 valid;
    rv_isa_pkg::reg_idx_t rd;
    logic [`XLEN-1:0]     data;
    logic                 illegal;
  } trace_t;

endpackage

`default_nettype wire

//--- rv_isa_pkg.sv
// instruction set encodings and the structs passed between pipeline stages
`default_nettype none

`include "core_defines.svh"

package rv_isa_pkg;

  // major opcodes handled by the core
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  // funct3 of the integer ALU group
  typedef enum logic [2:0] {
    F3_ADD_SUB = 3'b000,
    F3_SLL     = 3'b001,
    F3_SLT     = 3'b010,
    F3_SLTU    = 3'b011,
    F3_XOR     = 3'b100,
    F3_SRL_SRA = 3'b101,
    F3_OR      = 3'b110,
    F3_AND     = 3'b111
  } funct3_e;

  // funct3 of the SYSTEM group, same codes as the ALU group so kept apart
  localparam logic [2:0] F3_CSRRW = 3'b001;
  localparam logic [2:0] F3_CSRRS = 3'b010;

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SLT  = 4'd3,
    ALU_SLTU = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9
  } alu_op_e;

  typedef enum logic [1:0] {
    CSR_NONE  = 2'd0,
    CSR_WRITE = 2'd1,
    CSR_SET   = 2'd2
  } csr_op_e;

  typedef logic [$clog2(`REG_COUNT)-1:0] reg_idx_t;

  // control word held in the decode register
  typedef struct packed {
    logic              valid;
    alu_op_e           alu_op;
    logic              use_imm;
    logic [`XLEN-1:0]  imm;
    reg_idx_t          rs1;
    reg_idx_t          rs2;
    reg_idx_t          rd;
    logic              wb_en;
    csr_op_e           csr_op;
    logic [11:0]       csr_addr;
    logic              illegal;
  } decoded_t;

  // execute register contents
  typedef struct packed {
    logic              valid;
    reg_idx_t          rd;
    logic              wb_en;
    logic [`XLEN-1:0]  data;
    logic              illegal;
  } exec_result_t;

endpackage

`default_nettype wire

//--- core_defines.svh
// core widths, register count and CSR map shared by the mini core
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// data path width
`define XLEN 32

// architectural integer registers, x0 included
`define REG_COUNT 32

// board CSRs in the custom space
// LED register is read/write
`define CSR_LED_ADDR 12'h7C0
// button register sits in the read-only range
`define CSR_BTN_ADDR 12'hFC0

// board I/O widths
`define LED_WIDTH 4
`define BTN_WIDTH 4

`endif
